/* src.f */
hw/bus_pkg.sv
hw/map_pkg.sv
hw/data_ram.sv
hw/led_port.sv
hw/keys_port.sv
hw/mmc.sv
hw/soc_bus_top.sv
sim/mmc_properties.sv
sim/soc_bus_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the soc_bus testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module soc_bus_tb -o soc_bus_sim; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/soc_bus_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "All tests passed" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

/* sim/soc_bus_tb.sv */
`timescale 1ns/1ns

module soc_bus_tb
  import bus_pkg::*, map_pkg::*;
();

  localparam int MEM_WORDS = 1024;
  localparam int NUM_KEYS  = 4;
  localparam int ACK_WAIT  = 10;  // Cycles before a missing ack counts as lost.
  localparam int RAM_SLOTS = 16;

  localparam logic [31:0] LED_ADDR  = {LED_REGION, LED_BANK, 16'h0000};
  localparam logic [31:0] KEYS_ADDR = {KEYS_REGION, KEYS_BANK, 16'h0000};

  logic                clk;
  logic                rst;
  logic                req;
  logic                write;
  bus_addr_u           addr;
  logic [DATA_W-1:0]   wdata;
  byte_mask_t          rd_mask;
  byte_mask_t          wr_mask;
  logic [NUM_KEYS-1:0] keys;
  logic                ack;
  logic [DATA_W-1:0]   rdata;
  logic [7:0]          led;

  // Reference state.
  logic [DATA_W-1:0]   ram_model [int];
  logic [7:0]          led_model;
  logic [NUM_KEYS-1:0] key_meta_m;
  logic [NUM_KEYS-1:0] key_sync_m;

  // Set at posedge and checked at the following negedge.
  logic                primed;
  logic                ack_exp;
  logic [DATA_W-1:0]   exp_data;
  string               exp_name;
  string               test_name;

  int                  slot_idx [RAM_SLOTS];

  soc_bus_top #(.MEM_WORDS(MEM_WORDS), .NUM_KEYS(NUM_KEYS)) uut (
    .clk     (clk),     .rst     (rst),
    .req     (req),     .write   (write),
    .addr    (addr),    .wdata   (wdata),
    .rd_mask (rd_mask), .wr_mask (wr_mask),
    .keys    (keys),    .ack     (ack),
    .rdata   (rdata),   .led     (led)
  );

  always #20 clk = ~clk;

  function automatic logic [DATA_W-1:0] keep_lanes(input logic [DATA_W-1:0] data,
                                                   input byte_mask_t        mask);
    logic [DATA_W-1:0] res;
    res = data;
    for (int b = 0; b < DATA_W / 8; b++)
    begin
      if (!mask[b])
        res[8*b +: 8] = 8'h00;
    end
    return res;
  endfunction

  function automatic int word_index(input bus_addr_u a);
    return int'((a.word >> 2) % MEM_WORDS);
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(input bus_addr_u  a,
                                                      input logic       wr,
                                                      input byte_mask_t mask);
    logic [DATA_W-1:0] stored;
    stored = '0;
    if (wr)
      stored = '0; // Writes answer with zero data.
    else if (a.word <= MEM_ADDR_HI)
      stored = ram_model.exists(word_index(a)) ? ram_model[word_index(a)] : 'x;
    else if (a.f.region == LED_REGION && a.f.bank == LED_BANK)
      stored = {24'h000000, led_model};
    else if (a.f.region == KEYS_REGION && a.f.bank == KEYS_BANK)
      stored = DATA_W'(key_sync_m);
    return keep_lanes(stored, mask);
  endfunction

  function automatic void apply_write(input bus_addr_u         a,
                                      input logic [DATA_W-1:0] d,
                                      input byte_mask_t        mask);
    logic [DATA_W-1:0] stored;
    int                idx;
    idx = word_index(a);
    if (a.word <= MEM_ADDR_HI)
    begin
      stored = ram_model.exists(idx) ? ram_model[idx] : 'x;
      for (int b = 0; b < DATA_W / 8; b++)
      begin
        if (mask[b])
          stored[8*b +: 8] = d[8*b +: 8];
      end
      ram_model[idx] = stored;
    end
    else if (a.f.region == LED_REGION && a.f.bank == LED_BANK && mask[0])
      led_model = d[7:0];
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
                            input logic [DATA_W-1:0] actual);
    if (actual !== expected)
      stop_on_error($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic check_mask_led(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
    if (actual !== expected)
      stop_on_error($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
  endtask

  // The model advances once per rising edge.
  always @(posedge clk)
  begin
    primed  = 1'b1;
    ack_exp = 1'b0;
    if (!rst && req)
    begin
      ack_exp  = 1'b1;
      exp_name = test_name;
      exp_data = expected_read(addr, write, rd_mask);
      if (write)
        apply_write(addr, wdata, wr_mask);
    end
    key_sync_m = key_meta_m;
    key_meta_m = keys;
  end

  always @(negedge clk)
  begin
    if (primed)
    begin
      if (ack !== ack_exp)
        stop_on_error($sformatf("Handshake error near %s: ack is %b but %b was due",
                                exp_name, ack, ack_exp));
      if (ack_exp)
        check_data(exp_name, exp_data, rdata);
      check_mask_led("led pins", led_model, led);
    end
  end

  task automatic bus_access(input string name, input logic wr, input logic [31:0] a,
                            input logic [DATA_W-1:0] d, input byte_mask_t rm,
                            input byte_mask_t wm);
    int waited;
    @(negedge clk);
    test_name = name;
    req       = 1'b1;
    write     = wr;
    addr.word = a;
    wdata     = d;
    rd_mask   = rm;
    wr_mask   = wm;
    @(negedge clk);
    req    = 1'b0;
    waited = 0;
    while (ack !== 1'b1 && waited < ACK_WAIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (ack !== 1'b1)
      stop_on_error($sformatf("No ack within %0d cycles for %s", ACK_WAIT, name));
  endtask

  task automatic ram_masked_access();
    logic [31:0] a;
    int          slot;
    for (int i = 0; i < RAM_SLOTS; i++)
    begin
      slot_idx[i] = int'($urandom % MEM_WORDS);
      bus_access("ram init", 1'b1, 32'(slot_idx[i] * 4), $urandom, 4'h0, 4'hF);
    end
    for (int i = 0; i < 60; i++)
    begin
      slot = int'($urandom % RAM_SLOTS);
      // Any of the 32 aliases inside the RAM window.
      a = 32'(slot_idx[slot] * 4 + ($urandom % 32) * MEM_WORDS * 4 + $urandom % 4);
      if ($urandom % 2 == 1)
        bus_access("ram masked write", 1'b1, a, $urandom, 4'h0, byte_mask_t'($urandom));
      else
        bus_access("ram masked read", 1'b0, a, '0, byte_mask_t'($urandom), 4'h0);
    end
    for (int i = 0; i < RAM_SLOTS; i++)
    begin
      a = 32'(slot_idx[i] * 4 + 31 * MEM_WORDS * 4);
      bus_access("ram top alias read", 1'b0, a, '0, 4'hF, 4'h0);
    end
  endtask

  task automatic led_write_readback();
    logic [31:0] a;
    bus_access("led write", 1'b1, LED_ADDR, 32'h1234_56A5, 4'h0, 4'hF);
    bus_access("led read full", 1'b0, LED_ADDR, '0, 4'hF, 4'h0);
    bus_access("led write lane 0 off", 1'b1, LED_ADDR + 32'h4, 32'h0000_005A, 4'h0, 4'hE);
    bus_access("led read lane 0 only", 1'b0, LED_ADDR, '0, 4'h1, 4'h0);
    bus_access("led read lane 0 masked", 1'b0, LED_ADDR, '0, 4'hE, 4'h0);
    for (int i = 0; i < 12; i++)
    begin
      a = LED_ADDR | ($urandom & 32'h0000_FFFC);
      if ($urandom % 2 == 1)
        bus_access("led random write", 1'b1, a, $urandom, 4'h0, byte_mask_t'($urandom));
      else
        bus_access("led random read", 1'b0, a, '0, byte_mask_t'($urandom), 4'h0);
    end
  endtask

  task automatic key_sync_readback();
    for (int i = 0; i < 6; i++)
    begin
      @(negedge clk);
      keys = NUM_KEYS'($urandom);
      repeat (3) @(negedge clk); // Past both synchronizer stages.
      bus_access("keys read", 1'b0, KEYS_ADDR, '0, 4'hF, 4'h0);
      bus_access("keys read masked", 1'b0, KEYS_ADDR + 32'h8, '0, byte_mask_t'($urandom),
                 4'h0);
      bus_access("keys write ignored", 1'b1, KEYS_ADDR, $urandom, 4'h0, 4'hF);
      bus_access("keys read after write", 1'b0, KEYS_ADDR, '0, 4'hF, 4'h0);
    end
  endtask

  task automatic unmapped_zero_ack();
    logic [31:0] holes [6];
    holes = '{32'hC200_0000, 32'h8000_0000, 32'h0002_0000,
              32'hC001_0000, 32'hC101_0000, 32'hFFFF_FFFC};
    for (int i = 0; i < 6; i++)
    begin
      bus_access("unmapped read", 1'b0, holes[i], '0, 4'hF, 4'h0);
      bus_access("unmapped write", 1'b1, holes[i], $urandom, 4'h0, 4'hF);
      bus_access("unmapped read again", 1'b0, holes[i], '0, 4'hF, 4'h0);
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    req        = 1'b0;
    write      = 1'b0;
    addr       = '0;
    wdata      = '0;
    rd_mask    = '0;
    wr_mask    = '0;
    keys       = '0;
    led_model  = 8'h00;
    key_meta_m = '0;
    key_sync_m = '0;
    primed     = 1'b0;
    ack_exp    = 1'b0;
    exp_data   = '0;
    exp_name   = "reset";
    test_name  = "reset";
    void'($urandom(32'hb8bb_d5c4));

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    ram_masked_access();
    led_write_readback();
    key_sync_readback();
    unmapped_zero_ack();

    @(negedge clk); // A stray ack would still show in this idle cycle.
    $display("All tests passed");
    $finish;
  end

endmodule

/* sim/mmc_properties.sv */
`timescale 1ns/1ns

module mmc_properties
(
  input logic clk,
  input logic rst,
  input logic cpu_req,
  input logic cpu_ack,
  input logic mem_req,
  input logic led_req,
  input logic keys_req
);

  // Every ack answers the request of the cycle before.
  ack_follows_req: assert property (@(posedge clk) disable iff (rst) cpu_ack |-> $past(cpu_req))
    else $error("cpu_ack high without a request in the previous cycle");

  target_req_onehot: assert property (@(posedge clk) $onehot0({mem_req, led_req, keys_req}))
    else $error("more than one target request high");

  ack_low_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !cpu_ack)
    else $error("cpu_ack high during reset");

endmodule

bind mmc mmc_properties u_mmc_properties (
  .clk      (clk),
  .rst      (rst),
  .cpu_req  (cpu_req),
  .cpu_ack  (cpu_ack),
  .mem_req  (mem_req),
  .led_req  (led_req),
  .keys_req (keys_req)
);

/* hw/soc_bus_top.sv */
`timescale 1ns/1ns

module soc_bus_top
  import bus_pkg::*;
#(
  parameter int MEM_WORDS = 1024,
  parameter int NUM_KEYS  = 4
)
(
  input  logic                clk,
  input  logic                rst,
  input  logic                req,
  input  logic                write,
  input  bus_addr_u           addr,
  input  logic [DATA_W-1:0]   wdata,
  input  byte_mask_t          rd_mask,
  input  byte_mask_t          wr_mask,
  input  logic [NUM_KEYS-1:0] keys,
  output logic                ack,
  output logic [DATA_W-1:0]   rdata,
  output logic [7:0]          led
);

  logic              mem_req, mem_write, mem_ack;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata, mem_rdata;
  byte_mask_t        mem_rd_mask, mem_wr_mask;

  logic              led_req, led_write, led_ack;
  logic [DATA_W-1:0] led_wdata, led_rdata;
  byte_mask_t        led_rd_mask, led_wr_mask;

  logic              keys_req, keys_write, keys_ack;
  logic [DATA_W-1:0] keys_rdata;
  byte_mask_t        keys_rd_mask;

  // Peripheral offsets, key write data and key write mask stay open.
  mmc u_mmc (
    .clk          (clk),          .rst          (rst),
    .cpu_req      (req),          .cpu_write    (write),
    .cpu_addr     (addr),         .cpu_wdata    (wdata),
    .cpu_rd_mask  (rd_mask),      .cpu_wr_mask  (wr_mask),
    .cpu_ack      (ack),          .cpu_rdata    (rdata),
    .mem_req      (mem_req),      .mem_write    (mem_write),
    .mem_addr     (mem_addr),     .mem_wdata    (mem_wdata),
    .mem_rd_mask  (mem_rd_mask),  .mem_wr_mask  (mem_wr_mask),
    .mem_ack      (mem_ack),      .mem_rdata    (mem_rdata),
    .led_req      (led_req),      .led_write    (led_write),
    .led_addr     (),             .led_wdata    (led_wdata),
    .led_rd_mask  (led_rd_mask),  .led_wr_mask  (led_wr_mask),
    .led_ack      (led_ack),      .led_rdata    (led_rdata),
    .keys_req     (keys_req),     .keys_write   (keys_write),
    .keys_addr    (),             .keys_wdata   (),
    .keys_rd_mask (keys_rd_mask), .keys_wr_mask (),
    .keys_ack     (keys_ack),     .keys_rdata   (keys_rdata)
  );

  data_ram #(.MEM_WORDS(MEM_WORDS)) u_data_ram (
    .clk     (clk),         .rst     (rst),
    .req     (mem_req),     .write   (mem_write),
    .addr    (mem_addr),    .wdata   (mem_wdata),
    .rd_mask (mem_rd_mask), .wr_mask (mem_wr_mask),
    .ack     (mem_ack),     .rdata   (mem_rdata)
  );

  led_port u_led_port (
    .clk     (clk),         .rst     (rst),
    .req     (led_req),     .write   (led_write),
    .wdata   (led_wdata),   .rd_mask (led_rd_mask),
    .wr_mask (led_wr_mask), .ack     (led_ack),
    .rdata   (led_rdata),   .led     (led)
  );

  keys_port #(.NUM_KEYS(NUM_KEYS)) u_keys_port (
    .clk     (clk),          .rst     (rst),
    .req     (keys_req),     .write   (keys_write),
    .rd_mask (keys_rd_mask), .keys    (keys),
    .ack     (keys_ack),     .rdata   (keys_rdata)
  );

endmodule

/* hw/mmc.sv */
`timescale 1ns/1ns

module mmc
  import bus_pkg::*, map_pkg::*;
(
  input  logic              clk,
  input  logic              rst,

  input  logic              cpu_req,
  input  logic              cpu_write,
  input  bus_addr_u         cpu_addr,
  input  logic [DATA_W-1:0] cpu_wdata,
  input  byte_mask_t        cpu_rd_mask,
  input  byte_mask_t        cpu_wr_mask,
  output logic              cpu_ack,
  output logic [DATA_W-1:0] cpu_rdata,

  output logic              mem_req,
  output logic              mem_write,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  output byte_mask_t        mem_rd_mask,
  output byte_mask_t        mem_wr_mask,
  input  logic              mem_ack,
  input  logic [DATA_W-1:0] mem_rdata,

  output logic              led_req,
  output logic              led_write,
  output logic [ADDR_W-1:0] led_addr,
  output logic [DATA_W-1:0] led_wdata,
  output byte_mask_t        led_rd_mask,
  output byte_mask_t        led_wr_mask,
  input  logic              led_ack,
  input  logic [DATA_W-1:0] led_rdata,

  output logic              keys_req,
  output logic              keys_write,
  output logic [ADDR_W-1:0] keys_addr,
  output logic [DATA_W-1:0] keys_wdata,
  output byte_mask_t        keys_rd_mask,
  output byte_mask_t        keys_wr_mask,
  input  logic              keys_ack,
  input  logic [DATA_W-1:0] keys_rdata
);

  localparam logic [ADDR_W-1:0] LED_BASE  = {LED_REGION, LED_BANK, 16'h0000};
  localparam logic [ADDR_W-1:0] KEYS_BASE = {KEYS_REGION, KEYS_BANK, 16'h0000};

  logic mem_hit;
  logic led_hit;
  logic keys_hit;
  logic null_ack;

  // Unsigned wrap makes addresses below the base fail the limit test.
  assign mem_addr = cpu_addr.word - MEM_ADDR_LO;
  assign mem_hit  = mem_addr <= (MEM_ADDR_HI - MEM_ADDR_LO);

  assign led_hit  = (cpu_addr.f.region == LED_REGION) && (cpu_addr.f.bank == LED_BANK);
  assign keys_hit = (cpu_addr.f.region == KEYS_REGION) && (cpu_addr.f.bank == KEYS_BANK);

  assign led_addr  = cpu_addr.word - LED_BASE;
  assign keys_addr = cpu_addr.word - KEYS_BASE;

  assign mem_req  = cpu_req & mem_hit;
  assign led_req  = cpu_req & led_hit;
  assign keys_req = cpu_req & keys_hit;

  // Remaining request fields fan out unchanged.
  assign mem_write    = cpu_write;
  assign mem_wdata    = cpu_wdata;
  assign mem_rd_mask  = cpu_rd_mask;
  assign mem_wr_mask  = cpu_wr_mask;

  assign led_write    = cpu_write;
  assign led_wdata    = cpu_wdata;
  assign led_rd_mask  = cpu_rd_mask;
  assign led_wr_mask  = cpu_wr_mask;

  assign keys_write   = cpu_write;
  assign keys_wdata   = cpu_wdata;
  assign keys_rd_mask = cpu_rd_mask;
  assign keys_wr_mask = cpu_wr_mask;

  // Answers an unmapped address one cycle later so the CPU never stalls.
  always_ff @(posedge clk)
  begin
    if (rst)
      null_ack <= 1'b0;
    else
      null_ack <= cpu_req & ~(mem_hit | led_hit | keys_hit);
  end

  assign cpu_ack   = mem_ack | led_ack | keys_ack | null_ack;
  assign cpu_rdata = ({DATA_W{mem_ack}} & mem_rdata)
                   | ({DATA_W{led_ack}} & led_rdata)
                   | ({DATA_W{keys_ack}} & keys_rdata); // Null adds zero.

endmodule

/* hw/keys_port.sv */
`timescale 1ns/1ns

module keys_port
  import bus_pkg::*;
#(
  parameter int NUM_KEYS = 4
)
(
  input  logic                clk,
  input  logic                rst,
  input  logic                req,
  input  logic                write,
  input  byte_mask_t          rd_mask,
  input  logic [NUM_KEYS-1:0] keys,
  output logic                ack,
  output logic [DATA_W-1:0]   rdata
);

  logic [NUM_KEYS-1:0] key_meta;
  logic [NUM_KEYS-1:0] key_sync;

  // Two flops against metastability on the asynchronous pins.
  always_ff @(posedge clk)
  begin
    key_meta <= keys;
    key_sync <= key_meta;
  end

  // Writes are answered but have no effect.
  always_ff @(posedge clk)
  begin
    if (req)
      rdata <= write ? '0 : mask_bytes(DATA_W'(key_sync), rd_mask);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      ack <= 1'b0;
    else
      ack <= req;
  end

endmodule

/* hw/led_port.sv */
`timescale 1ns/1ns

module led_port
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  logic              write,
  input  logic [DATA_W-1:0] wdata,
  input  byte_mask_t        rd_mask,
  input  byte_mask_t        wr_mask,
  output logic              ack,
  output logic [DATA_W-1:0] rdata,
  output logic [7:0]        led
);

  // Only byte lane 0 reaches the register.
  always_ff @(posedge clk)
  begin
    if (rst)
      led <= 8'h00;
    else if (req && write && wr_mask[0])
      led <= wdata[7:0];
  end

  always_ff @(posedge clk)
  begin
    if (req)
      rdata <= write ? '0 : mask_bytes(DATA_W'(led), rd_mask);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      ack <= 1'b0;
    else
      ack <= req;
  end

endmodule

/* hw/data_ram.sv */
`timescale 1ns/1ns

module data_ram
  import bus_pkg::*;
#(
  parameter int MEM_WORDS = 1024
)
(
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  logic              write,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  input  byte_mask_t        rd_mask,
  input  byte_mask_t        wr_mask,
  output logic              ack,
  output logic [DATA_W-1:0] rdata
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0]  word_idx;

  // Word index of the byte offset wraps at the array depth.
  assign word_idx = IDX_W'(addr[ADDR_W-1:2] % MEM_WORDS);

  always_ff @(posedge clk)
  begin
    if (req)
    begin
      if (write)
      begin
        for (int b = 0; b < BYTES; b++)
        begin
          if (wr_mask[b])
            mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
        rdata <= '0;
      end
      else
        rdata <= mask_bytes(mem[word_idx], rd_mask);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      ack <= 1'b0;
    else
      ack <= req; // Fixed one-cycle latency.
  end

endmodule

/* hw/map_pkg.sv */
package map_pkg;

  // RAM window, byte addresses.
  localparam logic [31:0] MEM_ADDR_LO = 32'h0000_0000;
  localparam logic [31:0] MEM_ADDR_HI = 32'h0001_FFFF;

  // LED output register at C000_xxxx.
  localparam logic [7:0] LED_REGION  = 8'hC0;
  localparam logic [7:0] LED_BANK    = 8'h00;

  // Key input port at C100_xxxx.
  localparam logic [7:0] KEYS_REGION = 8'hC1;
  localparam logic [7:0] KEYS_BANK   = 8'h00;

  // C101_xxxx and up stay reserved for joystick and display.
  // Anything not listed here goes to the null responder.

endpackage

/* hw/bus_pkg.sv */
package bus_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int BYTES  = DATA_W / 8;

  typedef logic [BYTES-1:0] byte_mask_t; // One enable per byte lane.

  // Peripheral view of an address.
  typedef struct packed {
    logic [7:0]  region;
    logic [7:0]  bank;
    logic [15:0] offset;
  } addr_fields_t;

  typedef union packed {
    logic [ADDR_W-1:0] word; // Compared against the RAM window.
    addr_fields_t      f;
  } bus_addr_u;

  // Clears every byte lane whose enable is low.
  function automatic logic [DATA_W-1:0] mask_bytes(input logic [DATA_W-1:0] data,
                                                   input byte_mask_t        mask);
    logic [DATA_W-1:0] res;
    res = '0;
    for (int b = 0; b < BYTES; b++)
    begin
      if (mask[b])
        res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

endpackage
